// File: sim.f
spi_pkg.sv
spi_clk_timer.sv
spi_shift_reg.sv
spi_ctrl_fsm.sv
spi_master.sv
spi_slave_model.sv
tb_spi_master.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f sim.f --top-module tb_spi_master -o tb_sim; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "^Test completed successfully$"; then
  exit 0
fi
exit 1

// File: tb_spi_master.sv
`timescale 1ns/1ns

module tb_spi_master
  import spi_pkg::*;
();

  localparam int WAIT_LIMIT = 200;

  logic        clk;
  logic        rst_n;
  logic [11:0] cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        sclk;
  logic        cs;
  logic        mosi;
  logic        miso;
  logic        read_vld;
  logic [7:0]  read_data;
  logic [7:0]  rise_count;
  logic [2:0]  peek_addr;
  logic [7:0]  peek_data;
  logic [31:0] lfsr;
  logic [7:0]  expect_mem [0:7];
  int          err_cnt;
  int          pass_cnt;
  int          fail_cnt;

  spi_master UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model u_slave (
    .clk        (clk),
    .rst_n      (rst_n),
    .sclk       (sclk),
    .cs         (cs),
    .mosi       (mosi),
    .miso       (miso),
    .rise_count (rise_count),
    .peek_addr  (peek_addr),
    .peek_data  (peek_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_byte(output logic [7:0] v);
    v = '0;
    for (int i = 0; i < 8; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v    = {v[6:0], lfsr[0]};
    end
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    if (err_cnt == err_start)
    begin
      pass_cnt++;
      $display("%s: pass", name);
    end
    else
    begin
      fail_cnt++;
      $display("%s: FAIL with %0d errors", name, err_cnt - err_start);
    end
  endtask

  // Returns on a falling clk edge with cmd_rdy high.
  task automatic wait_ready(input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!cmd_rdy && cycles < WAIT_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!cmd_rdy)
    begin
      $display("cmd_rdy stayed low for %0d cycles during %s", WAIT_LIMIT, what);
      err_cnt++;
    end
  endtask

  task automatic send_cmd(input logic [11:0] cmd);
    wait_ready("command issue");
    @(posedge clk);
    cmd_in  <= cmd;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  task automatic collect_read(output logic [7:0] data, output int pulses);
    int cycles;
    pulses = 0;
    data   = '0;
    cycles = 0;
    do
    begin
      @(negedge clk);
      cycles++;
      if (read_vld)
      begin
        pulses++;
        data = read_data;
      end
    end while (!cmd_rdy && cycles < WAIT_LIMIT);
    if (!cmd_rdy)
    begin
      $display("read did not finish within %0d cycles", WAIT_LIMIT);
      err_cnt++;
    end
    @(negedge clk);
    if (read_vld)
      pulses++;  // A second or stretched pulse.
  endtask

  task automatic do_write(input logic [2:0] addr, input logic [7:0] data);
    send_cmd({OP_WRITE, addr, data});
    wait_ready("write");
    expect_mem[addr] = data;
  endtask

  task automatic do_read(input logic [2:0] addr, output logic [7:0] data);
    int pulses;
    send_cmd({OP_READ, addr, 8'h00});
    collect_read(data, pulses);
    check("read_vld pulses", 32'(pulses), 32'd1);
  endtask

  task automatic test_idle_state();
    int e0;
    e0 = err_cnt;
    @(negedge clk);
    check("cs", 32'(cs), 32'd1);
    check("sclk", 32'(sclk), 32'd0);
    check("mosi", 32'(mosi), 32'd0);
    check("read_vld", 32'(read_vld), 32'd0);
    check("cmd_rdy", 32'(cmd_rdy), 32'd1);
    report_test("idle_after_reset", e0);
  endtask

  task automatic test_reset_contents();
    int         e0;
    logic [7:0] data;
    e0 = err_cnt;
    for (int a = 0; a < 8; a++)
    begin
      do_read(3'(a), data);
      check("read_data", 32'(data), 32'(8'h10 + 8'(a)));
    end
    report_test("read_reset_contents", e0);
  endtask

  task automatic test_write_readback();
    int         e0;
    logic [7:0] data;
    e0 = err_cnt;
    for (int a = 0; a < 8; a++)
    begin
      random_byte(data);
      do_write(3'(a), data);
    end
    for (int a = 0; a < 8; a++)
    begin
      do_read(3'(a), data);
      check("read_data", 32'(data), 32'(expect_mem[a]));
      @(posedge clk);
      peek_addr <= 3'(a);
      @(negedge clk);
      check("slave reg", 32'(peek_data), 32'(expect_mem[a]));
    end
    report_test("write_then_read_back", e0);
  endtask

  task automatic test_bit_count();
    int         e0;
    int         pulses;
    logic [7:0] data;
    e0 = err_cnt;
    random_byte(data);
    do_write(3'd5, data);
    check("cs", 32'(cs), 32'd1);
    check("rise_count", 32'(rise_count), 32'd12);
    send_cmd({OP_READ, 3'd5, 8'h00});
    collect_read(data, pulses);
    check("cs", 32'(cs), 32'd1);
    check("rise_count", 32'(rise_count), 32'd12);
    check("read_data", 32'(data), 32'(expect_mem[5]));
    report_test("bit_count_per_transaction", e0);
  endtask

  task automatic test_busy_ignored();
    int         e0;
    int         pulses;
    logic [7:0] data;
    logic [7:0] orig;
    e0   = err_cnt;
    orig = expect_mem[6];
    send_cmd({OP_READ, 3'd2, 8'h00});
    repeat (4) @(posedge clk);
    cmd_in  <= {OP_WRITE, 3'd6, ~orig};  // Arrives while busy.
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
    collect_read(data, pulses);
    check("read_vld pulses", 32'(pulses), 32'd1);
    check("read_data", 32'(data), 32'(expect_mem[2]));
    repeat (3) @(negedge clk);
    check("cmd_rdy", 32'(cmd_rdy), 32'd1);
    check("cs", 32'(cs), 32'd1);
    do_read(3'd6, data);
    check("read_data", 32'(data), 32'(orig));
    report_test("busy_command_ignored", e0);
  endtask

  initial
  begin
    rst_n     <= 1'b0;
    cmd_in    <= '0;
    cmd_vld   <= 1'b0;
    peek_addr <= '0;
    lfsr      = 32'hf911_02f2;
    err_cnt   = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    for (int a = 0; a < 8; a++)
      expect_mem[a] = 8'h10 + 8'(a);
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    test_idle_state();
    test_reset_contents();
    test_write_readback();
    test_bit_count();
    test_busy_ignored();
    $display("Summary: %0d tests passed, %0d failed, %0d check errors",
             pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: spi_slave_model.sv
`timescale 1ns/1ns

module spi_slave_model (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sclk,
  input  logic       cs,
  input  logic       mosi,
  output logic       miso,
  output logic [7:0] rise_count,
  input  logic [2:0] peek_addr,
  output logic [7:0] peek_data
);

  localparam int CMD_WIDTH  = 12;
  localparam int HEAD_WIDTH = 4;

  logic [7:0]           regs [0:7];
  logic [CMD_WIDTH-2:0] rx_bits;
  logic [7:0]           tx_bits;
  logic [7:0]           head_reg;
  logic                 sclk_q;
  logic                 cs_q;
  logic                 sclk_rise;
  logic                 sclk_fall;

  // sclk edges are seen one clk cycle late.
  assign sclk_rise = !cs && sclk && !sclk_q;
  assign sclk_fall = !cs && !sclk && sclk_q;
  assign head_reg  = regs[rx_bits[2:0]];  // Address after four header bits.
  assign peek_data = regs[peek_addr];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sclk_q     <= 1'b0;
      cs_q       <= 1'b1;
      rise_count <= '0;
      rx_bits    <= '0;
      tx_bits    <= '0;
      miso       <= 1'b0;
      for (int i = 0; i < 8; i++)
        regs[i] <= 8'h10 + 8'(i);
    end
    else
    begin
      sclk_q <= sclk;
      cs_q   <= cs;
      if (!cs && cs_q)
        rise_count <= '0;  // New transaction.
      else if (sclk_rise)
      begin
        rise_count <= rise_count + 8'd1;
        rx_bits    <= {rx_bits[CMD_WIDTH-3:0], mosi};
        if ((rise_count == 8'(CMD_WIDTH - 1)) && rx_bits[CMD_WIDTH-2])
          regs[rx_bits[9:7]] <= {rx_bits[6:0], mosi};  // Last bit of a write.
      end
      if (sclk_fall)
      begin
        if ((rise_count == 8'(HEAD_WIDTH)) && !rx_bits[3])
        begin
          miso    <= head_reg[7];
          tx_bits <= {head_reg[6:0], 1'b0};
        end
        else if (rise_count > 8'(HEAD_WIDTH))
        begin
          miso    <= tx_bits[7];
          tx_bits <= {tx_bits[6:0], 1'b0};
        end
      end
    end
  end

endmodule

// File: spi_master.sv
`timescale 1ns/1ns

module spi_master
  import spi_pkg::*;
#(
  parameter int CMD_WIDTH  = 12,
  parameter int READ_WIDTH = 8,
  parameter int CLK_DIV    = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [CMD_WIDTH-1:0]  cmd_in,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  output logic                  sclk,
  output logic                  cs,
  output logic                  mosi,
  input  logic                  miso,
  output logic                  read_vld,
  output logic [READ_WIDTH-1:0] read_data
);

  timer_ctrl_t tctrl;
  sclk_tick_t  tick;
  shift_ctrl_t sctrl;
  logic        bits_done;
  logic        op;

  spi_ctrl_fsm #(
    .CMD_WIDTH  (CMD_WIDTH),
    .READ_WIDTH (READ_WIDTH)
  ) u_fsm (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_vld   (cmd_vld),
    .op        (op),
    .tick      (tick),
    .bits_done (bits_done),
    .cmd_rdy   (cmd_rdy),
    .cs        (cs),
    .tctrl     (tctrl),
    .sctrl     (sctrl)
  );

  spi_clk_timer #(
    .CLK_DIV (CLK_DIV)
  ) u_timer (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (tctrl),
    .tick      (tick),
    .bits_done (bits_done),
    .sclk      (sclk)
  );

  spi_shift_reg #(
    .CMD_WIDTH  (CMD_WIDTH),
    .READ_WIDTH (READ_WIDTH)
  ) u_shift (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .ctrl      (sctrl),
    .miso      (miso),
    .mosi      (mosi),
    .op        (op),
    .read_data (read_data),
    .read_vld  (read_vld)
  );

endmodule

// File: spi_ctrl_fsm.sv
`timescale 1ns/1ns

module spi_ctrl_fsm
  import spi_pkg::*;
#(
  parameter int CMD_WIDTH  = 12,
  parameter int READ_WIDTH = 8
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cmd_vld,
  input  logic        op,
  input  sclk_tick_t  tick,
  input  logic        bits_done,
  output logic        cmd_rdy,
  output logic        cs,
  output timer_ctrl_t tctrl,
  output shift_ctrl_t sctrl
);

  localparam int HEAD_WIDTH = CMD_WIDTH - READ_WIDTH;

  spi_state_t           state;
  spi_state_t           state_next;
  logic                 data_phase;
  logic                 run_next;
  logic [BIT_CNT_W-1:0] total_next;

  assign data_phase = (state == W_DATA) || (state == R_HEAD) || (state == R_DATA);

  always_comb
  begin
    state_next = state;
    case (state)
      IDLE:
      begin
        if (!cmd_rdy)  // Command was loaded on the previous edge.
        begin
          if (spi_op_t'(op) == OP_WRITE)
            state_next = W_START;
          else
            state_next = R_START;
        end
      end
      W_START:
        if (tick.fall)
          state_next = W_DATA;
      W_DATA:
        if (bits_done)
          state_next = W_FINISH;
      W_FINISH:
        if (tick.fall)
          state_next = IDLE;
      R_START:
        if (tick.fall)
          state_next = R_HEAD;
      R_HEAD:
        if (bits_done)
          state_next = R_DATA;
      R_DATA:
        if (bits_done)
          state_next = R_FINISH;
      R_FINISH:
        if (tick.fall)
          state_next = IDLE;
      default:
        state_next = IDLE;
    endcase
  end

  // Timer setup for the phase being entered.
  always_comb
  begin
    run_next   = 1'b0;
    total_next = '0;
    case (state_next)
      W_DATA:
      begin
        run_next   = 1'b1;
        total_next = BIT_CNT_W'(CMD_WIDTH);
      end
      R_HEAD:
      begin
        run_next   = 1'b1;
        total_next = BIT_CNT_W'(HEAD_WIDTH);
      end
      R_DATA:
      begin
        run_next   = 1'b1;
        total_next = BIT_CNT_W'(READ_WIDTH);
      end
      default:
      begin
        run_next   = 1'b0;
        total_next = '0;
      end
    endcase
  end

  always_comb
  begin
    sctrl.load       = (state == IDLE) && cmd_rdy && cmd_vld;
    sctrl.tx_shift   = data_phase && tick.fall;  // mosi moves after each fall.
    sctrl.rx_capture = (state == R_DATA) && tick.rise;
    sctrl.rx_done    = (state == R_FINISH) && tick.fall;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= IDLE;
      cmd_rdy <= 1'b1;
      cs      <= 1'b1;
      tctrl   <= '0;
    end
    else
    begin
      state <= state_next;
      cs    <= (state_next == IDLE);
      if (sctrl.load)
        cmd_rdy <= 1'b0;
      else if ((state != IDLE) && (state_next == IDLE))
        cmd_rdy <= 1'b1;  // Ready again as cs returns high.
      tctrl.run         <= run_next;
      tctrl.phase_start <= (state_next != state) && (state_next != IDLE);
      tctrl.bit_total   <= total_next;
    end
  end

endmodule

// File: spi_shift_reg.sv
`timescale 1ns/1ns

module spi_shift_reg
  import spi_pkg::*;
#(
  parameter int CMD_WIDTH  = 12,
  parameter int READ_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [CMD_WIDTH-1:0]  cmd_in,
  input  shift_ctrl_t           ctrl,
  input  logic                  miso,
  output logic                  mosi,
  output logic                  op,
  output logic [READ_WIDTH-1:0] read_data,
  output logic                  read_vld
);

  logic [CMD_WIDTH-1:0]  tx_q;
  logic [READ_WIDTH-1:0] rx_q;

  assign mosi = tx_q[CMD_WIDTH-1];  // MSB first.

  // Transmit side. Zeros shift in, so mosi ends low after each command.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_q <= '0;
      op   <= 1'b0;
    end
    else
    begin
      if (ctrl.load)
      begin
        tx_q <= cmd_in;
        op   <= cmd_in[CMD_WIDTH-1];
      end
      else if (ctrl.tx_shift)
      begin
        tx_q <= {tx_q[CMD_WIDTH-2:0], 1'b0};
      end
    end
  end

  // Receive side.
  always_ff @(posedge clk)
  begin
    if (ctrl.rx_capture)
      rx_q <= {rx_q[READ_WIDTH-2:0], miso};
  end

  always_ff @(posedge clk)
  begin
    if (ctrl.rx_done)
      read_data <= rx_q;  // Held until the next read ends.
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      read_vld <= 1'b0;
    else
      read_vld <= ctrl.rx_done;
  end

endmodule

// File: spi_clk_timer.sv
`timescale 1ns/1ns

module spi_clk_timer
  import spi_pkg::*;
#(
  parameter int CLK_DIV = 2
) (
  input  logic        clk,
  input  logic        rst_n,
  input  timer_ctrl_t ctrl,
  output sclk_tick_t  tick,
  output logic        bits_done,
  output logic        sclk
);

  localparam int HALF_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

  logic [HALF_W-1:0]    half_cnt;
  logic [HALF_W-1:0]    half_eff;
  logic                 armed;
  logic                 active;
  logic                 half_end;
  logic                 fall_cnt_en;
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic [BIT_CNT_W-1:0] bit_eff;

  // A phase with run low still times out once, for start and finish.
  assign active   = ctrl.run || ctrl.phase_start || armed;
  assign half_eff = ctrl.phase_start ? '0 : half_cnt;
  assign half_end = active && (half_eff == HALF_W'(CLK_DIV - 1));

  assign tick.rise = half_end && ctrl.run && !sclk;
  assign tick.fall = half_end && (sclk || !ctrl.run);

  // Only real sclk falls count as bits.
  assign fall_cnt_en = half_end && ctrl.run && sclk;
  assign bit_eff     = ctrl.phase_start ? '0 : bit_cnt;
  assign bits_done   = fall_cnt_en && (bit_eff == ctrl.bit_total - BIT_CNT_W'(1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      half_cnt <= '0;
      armed    <= 1'b0;
      sclk     <= 1'b0;
      bit_cnt  <= '0;
    end
    else
    begin
      if (!active || half_end)
        half_cnt <= '0;
      else
        half_cnt <= half_eff + HALF_W'(1);

      armed <= (armed || ctrl.phase_start) && !ctrl.run && !half_end;

      if (ctrl.run && half_end)
        sclk <= !sclk;
      else if (!ctrl.run)
        sclk <= 1'b0;  // Idles low in mode 0.

      if (fall_cnt_en)
        bit_cnt <= bit_eff + BIT_CNT_W'(1);
      else
        bit_cnt <= bit_eff;
    end
  end

endmodule

// File: spi_pkg.sv
package spi_pkg;

  localparam int BIT_CNT_W = 8;  // Wide enough for any CMD_WIDTH in use.

  typedef enum logic [2:0] {
    IDLE,
    W_START,
    W_DATA,
    W_FINISH,
    R_START,
    R_HEAD,
    R_DATA,
    R_FINISH
  } spi_state_t;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } spi_op_t;

  // Both strobes are high in the cycle before sclk changes.
  typedef struct packed {
    logic rise;
    logic fall;
  } sclk_tick_t;

  typedef struct packed {
    logic                 run;          // sclk toggles.
    logic                 phase_start;  // First cycle of a phase.
    logic [BIT_CNT_W-1:0] bit_total;    // Bits in the current phase.
  } timer_ctrl_t;

  typedef struct packed {
    logic load;
    logic tx_shift;
    logic rx_capture;
    logic rx_done;
  } shift_ctrl_t;

endpackage
